//--- common/ppu_defs.svh
`ifndef PPU_DEFS_SVH
`define PPU_DEFS_SVH

// Background tiling of one 640 pixel line
`define PPU_TILES_PER_LINE   40
`define PPU_TILES_PER_WORD   4     // Tile map entries packed into one 32-bit word
`define PPU_WORDS_PER_ROW    10

// Tile geometry
`define PPU_TILE_LINES       16
`define PPU_PIXELS_PER_TILE  16

`define PPU_PALETTE_ENTRIES  8     // Two palettes of four colours

// Memory address widths
`define PPU_TILE_BUF_AW      9
`define PPU_TILE_GFX_AW      11
`define PPU_PALETTE_AW       3

// VGA counters
`define PPU_HCOUNT_W         11
`define PPU_VCOUNT_W         10

`endif

//--- common/ppu_pkg.sv
`include "ppu_defs.svh"

package ppu_pkg;

    typedef logic [23:0] color_t;  // RGB, 8 bits each

    // Pixel 0 is the leftmost one and sits in the top two bits
    typedef logic [0:`PPU_PIXELS_PER_TILE-1][1:0] tile_row_t;

    typedef struct packed {
        logic       palette;  // Selects upper or lower half of the palette
        logic [6:0] id;
    } tile_map_entry_t;

    typedef struct packed {
        logic      palette;
        tile_row_t row;
    } line_tile_t;

    typedef struct packed {
        logic [`PPU_HCOUNT_W-1:0] hcount;
        logic [`PPU_VCOUNT_W-1:0] vcount;
        logic                     vblank;
        logic                     hsync;
    } raster_t;

    typedef struct packed {
        logic [`PPU_TILE_BUF_AW-1:0] tile_buf_addr;
        logic [`PPU_TILE_GFX_AW-1:0] tile_gfx_addr;
    } bg_mem_req_t;

    typedef struct packed {
        logic [31:0] tile_buf_data;  // Four tile map entries, entry 0 in the low byte
        tile_row_t   tile_gfx_data;
    } bg_mem_rsp_t;

endpackage

//--- logic/entry_store.sv
`timescale 1ns/1ps

module entry_store import ppu_pkg::*; #(
    parameter type entry_t = color_t,
    parameter int  DEPTH   = 8
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     wr_en,
    input  logic [$clog2(DEPTH)-1:0] wr_index,
    input  entry_t                   wr_data,
    input  logic [$clog2(DEPTH)-1:0] rd_index,
    output entry_t                   rd_data
);

    entry_t entries [DEPTH];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                entries[i] <= '0;
            end
        end else if (wr_en) begin
            entries[wr_index] <= wr_data;
        end
    end

    // Indices past the last entry read as zero
    assign rd_data = (rd_index < DEPTH) ? entries[rd_index] : '0;

endmodule

//--- fetch/palette_fetch.sv
`timescale 1ns/1ps
`include "ppu_defs.svh"

module palette_fetch import ppu_pkg::*; (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       vblank,
    output logic [`PPU_PALETTE_AW-1:0] palette_addr,
    input  color_t                     palette_data,
    output logic                       wr_en,
    output logic [`PPU_PALETTE_AW-1:0] wr_index,
    output color_t                     wr_data
);

    localparam int AW = `PPU_PALETTE_AW;

    logic [AW:0]   load_cnt;   // Counts up to the entry count, then holds
    logic          load;
    logic          addr_valid; // Data on palette_data is to be written
    logic [AW-1:0] addr_d;

    assign load = vblank && (load_cnt < (AW+1)'(`PPU_PALETTE_ENTRIES));

    // Address goes out in the same cycle the counter points at it
    assign palette_addr = load ? load_cnt[AW-1:0] : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            load_cnt   <= '0;
            addr_valid <= 1'b0;
        end else begin
            addr_valid <= load;
            if (!vblank) begin
                load_cnt <= '0;  // Rearm for the next frame
            end else if (load) begin
                load_cnt <= load_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        addr_d <= palette_addr;
    end

    // Memory answers one cycle later
    assign wr_en    = addr_valid;
    assign wr_index = addr_d;
    assign wr_data  = palette_data;

endmodule

//--- fetch/line_fetch.sv
`timescale 1ns/1ps
`include "ppu_defs.svh"

module line_fetch import ppu_pkg::*; (
    input  logic                                   clk,
    input  logic                                   reset,
    input  raster_t                                raster,
    output bg_mem_req_t                            mem_req,
    input  bg_mem_rsp_t                            mem_rsp,
    output logic                                   wr_en,
    output logic [$clog2(`PPU_TILES_PER_LINE)-1:0] wr_index,
    output line_tile_t                             wr_data
);

    localparam int IW     = $clog2(`PPU_TILES_PER_LINE);
    localparam int BUF_AW = `PPU_TILE_BUF_AW;
    localparam int GFX_AW = `PPU_TILE_GFX_AW;

    tile_map_entry_t [`PPU_TILES_PER_WORD-1:0] map_word;

    logic            fetch_en;
    logic            s1_issue;
    logic [IW-1:0]   ptr;        // Tile addressed in stage 1
    logic            s2_valid;
    logic [IW-1:0]   s2_k;
    logic [1:0]      s2_slot;
    tile_map_entry_t s2_entry;
    logic            s3_valid;
    logic [IW-1:0]   s3_k;
    logic            s3_palette;

    assign fetch_en = raster.hsync && !raster.vblank;  // Vblank wins over hsync
    assign s1_issue = fetch_en && (ptr < IW'(`PPU_TILES_PER_LINE));

    // Stage 1 tile map word of this tile row
    always_comb begin
        mem_req.tile_buf_addr = '0;
        if (s1_issue) begin
            mem_req.tile_buf_addr = BUF_AW'(raster.vcount / `PPU_TILE_LINES
                                            * `PPU_WORDS_PER_ROW
                                            + ptr / `PPU_TILES_PER_WORD);
        end
    end

    // Stage 2 picks the entry and addresses its graphics row
    assign map_word = mem_rsp.tile_buf_data;
    assign s2_slot  = 2'(s2_k % `PPU_TILES_PER_WORD);
    assign s2_entry = map_word[s2_slot];

    always_comb begin
        mem_req.tile_gfx_addr = '0;
        if (s2_valid) begin
            mem_req.tile_gfx_addr = GFX_AW'(s2_entry.id * `PPU_TILE_LINES
                                            + raster.vcount % `PPU_TILE_LINES);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ptr      <= '0;
            s2_valid <= 1'b0;
            s3_valid <= 1'b0;
        end else begin
            if (!fetch_en) begin
                ptr <= '0;
            end else if (s1_issue) begin
                ptr <= ptr + 1'b1;
            end
            s2_valid <= s1_issue;
            s3_valid <= s2_valid && fetch_en;
        end
    end

    always_ff @(posedge clk) begin
        s2_k       <= ptr;
        s3_k       <= s2_k;
        s3_palette <= s2_entry.palette;  // Travels alongside the gfx read
    end

    // Stage 3 stores the returned row
    assign wr_en    = s3_valid;
    assign wr_index = s3_k;
    assign wr_data  = '{palette: s3_palette, row: mem_rsp.tile_gfx_data};

endmodule

//--- render/bg_pixel_out.sv
`timescale 1ns/1ps
`include "ppu_defs.svh"

module bg_pixel_out import ppu_pkg::*; (
    input  logic                                    clk,
    input  logic                                    reset,
    input  raster_t                                 raster,
    output logic [$clog2(`PPU_TILES_PER_LINE)-1:0]  tile_index,
    input  line_tile_t                              tile,
    output logic [$clog2(`PPU_PALETTE_ENTRIES)-1:0] palette_index,
    input  color_t                                  color,
    output color_t                                  pixel_color
);

    localparam int TW    = $clog2(`PPU_TILES_PER_LINE);
    localparam int PW    = $clog2(`PPU_PALETTE_ENTRIES);
    localparam int PIX_W = $clog2(`PPU_PIXELS_PER_TILE);
    localparam int SPAN  = 2 * `PPU_PIXELS_PER_TILE;  // hcount steps per tile

    logic             active;
    logic [PIX_W-1:0] pixel_num;
    logic [1:0]       pixel;

    assign active = !raster.vblank && !raster.hsync;

    // Each pixel is shown for two hcount values
    assign tile_index = TW'(raster.hcount / SPAN);
    assign pixel_num  = PIX_W'((raster.hcount % SPAN) / 2);
    assign pixel      = tile.row[pixel_num];

    // Palette bit picks the upper four colours
    assign palette_index = PW'(pixel + 4 * tile.palette);

    always_ff @(posedge clk) begin
        if (reset) begin
            pixel_color <= '0;
        end else if (active) begin
            pixel_color <= color;
        end
    end

endmodule

//--- logic/ppu_bg_top.sv
`timescale 1ns/1ps
`include "ppu_defs.svh"

module ppu_bg_top import ppu_pkg::*; (
    input  logic                       clk,
    input  logic                       reset,
    input  raster_t                    raster,
    output bg_mem_req_t                mem_req,
    input  bg_mem_rsp_t                mem_rsp,
    output logic [`PPU_PALETTE_AW-1:0] palette_addr,
    input  color_t                     palette_data,
    output color_t                     pixel_color
);

    localparam int PAL_IW  = $clog2(`PPU_PALETTE_ENTRIES);
    localparam int LINE_IW = $clog2(`PPU_TILES_PER_LINE);

    // Palette store side
    logic              pal_wr_en;
    logic [PAL_IW-1:0] pal_wr_index;
    color_t            pal_wr_data;
    logic [PAL_IW-1:0] pal_rd_index;
    color_t            pal_rd_data;

    // Line store side
    logic               line_wr_en;
    logic [LINE_IW-1:0] line_wr_index;
    line_tile_t         line_wr_data;
    logic [LINE_IW-1:0] line_rd_index;
    line_tile_t         line_rd_data;

    palette_fetch i_palette_fetch (
        .clk, .reset,
        .vblank       (raster.vblank),
        .palette_addr, .palette_data,
        .wr_en        (pal_wr_en),
        .wr_index     (pal_wr_index),
        .wr_data      (pal_wr_data)
    );

    line_fetch i_line_fetch (
        .clk, .reset, .raster, .mem_req, .mem_rsp,
        .wr_en    (line_wr_en),
        .wr_index (line_wr_index),
        .wr_data  (line_wr_data)
    );

    entry_store #(.entry_t(color_t), .DEPTH(`PPU_PALETTE_ENTRIES)) palette_store (
        .clk, .reset,
        .wr_en (pal_wr_en), .wr_index (pal_wr_index), .wr_data (pal_wr_data),
        .rd_index (pal_rd_index), .rd_data (pal_rd_data)
    );

    entry_store #(.entry_t(line_tile_t), .DEPTH(`PPU_TILES_PER_LINE)) line_store (
        .clk, .reset,
        .wr_en (line_wr_en), .wr_index (line_wr_index), .wr_data (line_wr_data),
        .rd_index (line_rd_index), .rd_data (line_rd_data)
    );

    bg_pixel_out i_bg_pixel_out (
        .clk, .reset, .raster,
        .tile_index    (line_rd_index),
        .tile          (line_rd_data),
        .palette_index (pal_rd_index),
        .color         (pal_rd_data),
        .pixel_color
    );

endmodule

//--- test/ppu_bg_props.sv
`timescale 1ns/1ps
`include "ppu_defs.svh"

module ppu_bg_props import ppu_pkg::*; (
    input logic                       clk,
    input logic                       reset,
    input raster_t                    raster,
    input bg_mem_req_t                mem_req,
    input logic [`PPU_PALETTE_AW-1:0] palette_addr,
    input color_t                     pixel_color
);

    int fail_count = 0;  // Failed assertions so far

    // Tile map holds 30 rows of 10 words
    buf_addr_in_map: assert property (@(posedge clk) disable iff (reset)
        mem_req.tile_buf_addr < 9'd300)
        else begin
            fail_count++;
            $error("tile_buf_addr %0d is past the tile map", mem_req.tile_buf_addr);
        end

    color_held_in_blanking: assert property (@(posedge clk) disable iff (reset)
        (raster.hsync || raster.vblank) |=> $stable(pixel_color))
        else begin
            fail_count++;
            $error("pixel_color changed during blanking");
        end

    addr_zero_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> (mem_req == '0 && palette_addr == '0))
        else begin
            fail_count++;
            $error("Memory addresses not zero after reset");
        end

endmodule

bind ppu_bg_top ppu_bg_props i_ppu_bg_props (
    .clk, .reset, .raster, .mem_req, .palette_addr, .pixel_color
);

//--- test/ppu_bg_tb.sv
`timescale 1ns/1ps
`include "ppu_defs.svh"

module ppu_bg_tb import ppu_pkg::*; ();

    localparam int MAP_WORDS = 300;  // 30 tile rows of 10 words
    localparam int GFX_ROWS  = 2048;
    localparam int HW        = `PPU_HCOUNT_W;
    localparam int VW        = `PPU_VCOUNT_W;
    localparam int BUF_AW    = `PPU_TILE_BUF_AW;
    localparam int GFX_AW    = `PPU_TILE_GFX_AW;
    localparam int PAL_AW    = `PPU_PALETTE_AW;

    logic                clk;
    logic                reset;
    raster_t             raster;
    bg_mem_req_t         mem_req;
    bg_mem_rsp_t         mem_rsp      = '0;
    logic [PAL_AW-1:0]   palette_addr;
    color_t              palette_data = '0;
    color_t              pixel_color;

    logic [31:0] tile_map [MAP_WORDS];
    logic [31:0] tile_gfx [GFX_ROWS];
    color_t      palette_mem [`PPU_PALETTE_ENTRIES];

    integer seed;
    color_t last_color;  // Value pixel_color must hold through blanking

    ppu_bg_top i_ppu_bg_top (
        .clk, .reset, .raster, .mem_req, .mem_rsp,
        .palette_addr, .palette_data, .pixel_color
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    // Synchronous read memories, data one cycle after the address
    always @(posedge clk) begin
        mem_rsp.tile_buf_data <= tile_map[mem_req.tile_buf_addr];
        mem_rsp.tile_gfx_data <= tile_gfx[mem_req.tile_gfx_addr];
        palette_data          <= palette_mem[palette_addr];
    end

    task automatic report_error(string line);
        $display("%s", line);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic compare_color(color_t want, color_t got, string name);
        if (got !== want) begin
            report_error($sformatf("[FAIL] time=%0t %s expected=%h actual=%h",
                                   $time, name, want, got));
        end
    endtask

    task automatic compare_addr(bg_mem_req_t want, bg_mem_req_t got, string name);
        if (got !== want) begin
            report_error($sformatf("[FAIL] time=%0t %s expected=%0d/%0d actual=%0d/%0d",
                                   $time, name, want.tile_buf_addr, want.tile_gfx_addr,
                                   got.tile_buf_addr, got.tile_gfx_addr));
        end
    endtask

    task automatic compare_pal_addr(logic [PAL_AW-1:0] want, logic [PAL_AW-1:0] got,
                                    string name);
        if (got !== want) begin
            report_error($sformatf("[FAIL] time=%0t %s expected=%0d actual=%0d",
                                   $time, name, want, got));
        end
    endtask

    task automatic fill_random();
        for (int i = 0; i < MAP_WORDS; i++) begin
            tile_map[BUF_AW'(i)] = $random(seed);
        end
        for (int i = 0; i < GFX_ROWS; i++) begin
            tile_gfx[GFX_AW'(i)] = $random(seed);
        end
        for (int i = 0; i < `PPU_PALETTE_ENTRIES; i++) begin
            palette_mem[PAL_AW'(i)] = color_t'($random(seed));
        end
    endtask

    // Call right after a rising edge
    task automatic drive_raster(int hcount, int vcount, logic vblank, logic hsync);
        raster_t next;
        next.hcount = HW'(hcount);
        next.vcount = VW'(vcount);
        next.vblank = vblank;
        next.hsync  = hsync;
        raster <= next;
    endtask

    function automatic logic [BUF_AW-1:0] map_addr(int vcount, int k);
        return BUF_AW'((vcount / `PPU_TILE_LINES) * `PPU_WORDS_PER_ROW
                       + k / `PPU_TILES_PER_WORD);
    endfunction

    // Entry 0 of a word sits in the low byte
    function automatic tile_map_entry_t map_entry(int vcount, int k);
        logic [31:0] shifted;
        shifted = tile_map[map_addr(vcount, k)] >> (8 * (k % `PPU_TILES_PER_WORD));
        return tile_map_entry_t'(shifted[7:0]);
    endfunction

    task automatic set_map_entry(int vcount, int k, tile_map_entry_t entry);
        logic [BUF_AW-1:0] addr;
        int                shift;
        addr  = map_addr(vcount, k);
        shift = 8 * (k % `PPU_TILES_PER_WORD);
        tile_map[addr] = (tile_map[addr] & ~(32'hff << shift)) | (32'(entry) << shift);
    endtask

    function automatic logic [GFX_AW-1:0] gfx_addr(logic [6:0] id, int vcount);
        return GFX_AW'(int'(id) * `PPU_TILE_LINES + vcount % `PPU_TILE_LINES);
    endfunction

    // Cycle 0 is the first hsync cycle
    function automatic bg_mem_req_t expected_req(int cyc, int vcount);
        bg_mem_req_t req;
        req = '0;
        if (cyc < `PPU_TILES_PER_LINE) begin
            req.tile_buf_addr = map_addr(vcount, cyc);
        end
        if (cyc >= 1 && cyc <= `PPU_TILES_PER_LINE) begin
            req.tile_gfx_addr = gfx_addr(map_entry(vcount, cyc - 1).id, vcount);
        end
        return req;
    endfunction

    function automatic color_t expected_color(int hcount, int vcount);
        tile_map_entry_t entry;
        logic [31:0]     shifted;
        int              index;
        entry   = map_entry(vcount, hcount / 32);
        shifted = tile_gfx[gfx_addr(entry.id, vcount)] >> (30 - 2 * ((hcount % 32) / 2));
        index   = int'(shifted[1:0]) + 4 * int'(entry.palette);
        return palette_mem[PAL_AW'(index)];
    endfunction

    task automatic load_palette();
        int cyc;
        cyc = 0;
        @(posedge clk);
        drive_raster(0, 0, 1'b1, 1'b0);
        @(negedge clk);
        while (palette_addr != PAL_AW'(`PPU_PALETTE_ENTRIES - 1)) begin
            compare_color(last_color, pixel_color, "pixel_color");
            if (cyc == 12) begin
                report_error("Palette fetch did not reach its last entry within 12 cycles");
            end
            cyc++;
            @(negedge clk);
        end
        while (cyc < 20) begin  // Rest of the 20 cycle vblank
            compare_color(last_color, pixel_color, "pixel_color");
            cyc++;
            @(negedge clk);
        end
    endtask

    task automatic fetch_line(int vcount);
        @(posedge clk);
        drive_raster(0, vcount, 1'b0, 1'b1);
        for (int cyc = 0; cyc < 45; cyc++) begin
            @(negedge clk);
            compare_addr(expected_req(cyc, vcount), mem_req, "mem_req");
            compare_color(last_color, pixel_color, "pixel_color");
        end
    endtask

    // pixel_color lags hcount by one cycle
    task automatic render_line(int vcount);
        for (int h = 0; h < 1280; h++) begin
            @(posedge clk);
            drive_raster(h, vcount, 1'b0, 1'b0);
            @(negedge clk);
            if (h == 0) begin
                compare_color(last_color, pixel_color, "pixel_color");
            end else begin
                compare_color(expected_color(h - 1, vcount), pixel_color, "pixel_color");
            end
        end
        last_color = expected_color(1279, vcount);
    endtask

    task automatic after_reset();
        @(negedge clk);
        compare_color('0, pixel_color, "pixel_color");
        compare_addr('0, mem_req, "mem_req");
        compare_pal_addr('0, palette_addr, "palette_addr");
    endtask

    // Palette 0 tiles with one colour rows, pixel value k mod 4 in tile k
    task automatic palette_load_line();
        for (int k = 0; k < `PPU_TILES_PER_LINE; k++) begin
            set_map_entry(37, k, '{palette: 1'b0, id: 7'(k + 8)});
            tile_gfx[gfx_addr(7'(k + 8), 37)] = {16{2'(k % 4)}};
        end
        load_palette();
        fetch_line(37);
        render_line(37);
    endtask

    task automatic random_line();
        fill_random();
        load_palette();
        fetch_line(201);
        render_line(201);
    endtask

    task automatic blanking_hold();
        fetch_line(322);  // Checks the held colour through hsync
        render_line(322);
    endtask

    initial begin
        seed        = 32'h8239;
        last_color  = '0;
        reset       = 1'b1;
        raster      = '0;
        fill_random();
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        after_reset();
        palette_load_line();
        random_line();
        blanking_hold();
        if (i_ppu_bg_top.i_ppu_bg_props.fail_count == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            $display("Testbench failed");
            $fatal(1, "Assertions on the DUT failed");
        end
    end

endmodule

//--- build.f
+incdir+common
common/ppu_pkg.sv
logic/entry_store.sv
fetch/palette_fetch.sv
fetch/line_fetch.sv
render/bg_pixel_out.sv
logic/ppu_bg_top.sv
test/ppu_bg_props.sv
test/ppu_bg_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f build.f --top-module ppu_bg_tb -o ppu_bg_sim

out=$(./obj_dir/ppu_bg_sim 2>&1 || true)
echo "$out"
echo "$out" | grep -q "^Testbench passed$"
